/* stepper_spi.f */
+incdir+design
design/stepper_cmd_pkg.sv
design/stepper_motion_pkg.sv
design/spi_word_receiver.sv
design/spi_command_decoder.sv
design/move_queue.sv
design/dda_step_generator.sv
design/stepper_spi_top.sv
test/stepper_spi_sva.sv
test/stepper_spi_tb.sv

/* Bender.yml */
package:
  name: stepper_spi

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/stepper_cmd_pkg.sv
      - design/stepper_motion_pkg.sv
      - design/spi_word_receiver.sv
      - design/spi_command_decoder.sv
      - design/move_queue.sv
      - design/dda_step_generator.sv
      - design/stepper_spi_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/stepper_spi_sva.sv
      - test/stepper_spi_tb.sv

/* test/stepper_spi_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "stepper_cfg.svh"

module stepper_spi_tb;

  localparam int MAX_TESTS = 12;

  logic        CLK;
  logic        arst_n;
  logic        sck;
  logic        cs_n;
  logic        copi;
  logic [63:0] encoder_count;
  logic        cipo;
  logic        step;
  logic        dir;
  logic        enable;
  logic [2:0]  microsteps;
  logic [7:0]  current;
  logic        buffer_dtr;
  logic        move_done;

  // Stimulus table with one row per host message
  string       tbl_name [MAX_TESTS];
  logic [63:0] tbl_word [MAX_TESTS][4];
  int          tbl_len  [MAX_TESTS];
  logic [63:0] tbl_exp  [MAX_TESTS];
  int          n_tests;

  integer             seed;
  int                 errors;
  int                 failed_tests;
  int                 step_count = 0;
  int                 done_count = 0;
  longint             wd_cycles = 0;
  logic signed [63:0] model_accum;

  stepper_spi_top u_stepper_spi_top (
    .CLK           (CLK),
    .arst_n        (arst_n),
    .sck           (sck),
    .cs_n          (cs_n),
    .copi          (copi),
    .encoder_count (encoder_count),
    .cipo          (cipo),
    .step          (step),
    .dir           (dir),
    .enable        (enable),
    .microsteps    (microsteps),
    .current       (current),
    .buffer_dtr    (buffer_dtr),
    .move_done     (move_done)
  );

  bind move_queue stepper_spi_sva u_queue_sva (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .push       (push),
    .pop        (pop),
    .head_valid (head_valid),
    .buffer_dtr (buffer_dtr),
    .step       (1'b0)
  );

  bind dda_step_generator stepper_spi_sva u_dda_sva (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .push       (1'b0),
    .pop        (pop),
    .head_valid (head_valid),
    .buffer_dtr (1'b1),
    .step       (step)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    if (step) begin
      step_count <= step_count + 1;
    end
    if (move_done) begin
      done_count <= done_count + 1;
    end
  end

  function automatic logic [63:0] header_word(input logic [7:0] op, input logic [7:0] b1,
                                              input logic [7:0] b0);
    return {op, 40'd0, b1, b0};
  endfunction

  task automatic add_test(input string name, input logic [63:0] w0, input logic [63:0] w1,
                          input logic [63:0] w2, input logic [63:0] w3, input int len,
                          input logic [63:0] exp);
    tbl_name[n_tests]    = name;
    tbl_word[n_tests][0] = w0;
    tbl_word[n_tests][1] = w1;
    tbl_word[n_tests][2] = w2;
    tbl_word[n_tests][3] = w3;
    tbl_len[n_tests]     = len;
    tbl_exp[n_tests]     = exp;
    n_tests++;
  endtask

  // Move rows carry duration, increment and accel as data words
  // Expected field of a move row is buffer_dtr after its push
  task automatic fill_table();
    n_tests = 0;
    add_test("motor_enable", header_word(stepper_cmd_pkg::CMD_MOTOR_ENABLE, 8'd0, 8'h01),
             64'd0, 64'd0, 64'd0, 1, 64'd1);
    add_test("motor_config", header_word(stepper_cmd_pkg::CMD_MOTOR_CONFIG, 8'd200, 8'h05),
             64'd0, 64'd0, 64'd0, 1, {53'd0, 3'd5, 8'd200});
    add_test("api_version", header_word(stepper_cmd_pkg::CMD_API_VERSION, 8'd0, 8'd0),
             64'hdead_beef_0000_0001, 64'd0, 64'd0, 2,
             {40'd0, `STEPPER_VERSION_MAJOR, `STEPPER_VERSION_MINOR, `STEPPER_VERSION_PATCH});
    add_test("clock_divisor", header_word(stepper_cmd_pkg::CMD_CLK_DIVISOR, 8'd0, 8'd3),
             64'd0, 64'd0, 64'd0, 1, 64'd3);
    add_test("move_accel", header_word(stepper_cmd_pkg::CMD_COORDINATED_STEP, 8'd0, 8'h01),
             64'd300, 64'h0000_0000_2000_0000, 64'h0000_0000_0010_0000, 4, 64'd1);
    // Ends the single move before the queue batch starts
    add_test("motor_disable", header_word(stepper_cmd_pkg::CMD_MOTOR_ENABLE, 8'd0, 8'h00),
             64'd0, 64'd0, 64'd0, 1, 64'd0);
    add_test("queue_move_1", header_word(stepper_cmd_pkg::CMD_COORDINATED_STEP, 8'd0, 8'h00),
             64'd4000, 64'h0000_0000_4000_0000, 64'd0, 4, 64'd1);
    add_test("queue_move_2", header_word(stepper_cmd_pkg::CMD_COORDINATED_STEP, 8'd0, 8'h00),
             64'd4000, 64'h0000_0000_3000_0000, 64'h0000_0000_0000_1000, 4, 64'd1);
    add_test("queue_move_3", header_word(stepper_cmd_pkg::CMD_COORDINATED_STEP, 8'd0, 8'h01),
             64'd4000, 64'hffff_ffff_c000_0000, 64'd0, 4, 64'd1);
    add_test("queue_move_4", header_word(stepper_cmd_pkg::CMD_COORDINATED_STEP, 8'd0, 8'h00),
             64'd4000, 64'h0000_0000_5000_0000, 64'd0, 4, 64'd1);
    // Fifth move fills the queue behind the running one
    add_test("queue_move_5", header_word(stepper_cmd_pkg::CMD_COORDINATED_STEP, 8'd0, 8'h00),
             64'd4000, 64'h0000_0000_4000_0000, 64'd0, 4, 64'd0);
  endtask

  // Word time plus move time at the divisor in force
  function automatic longint watchdog_budget();
    longint total;
    longint div;
    int     i;
    total = 400;
    div   = `STEPPER_DEFAULT_DIVISOR;
    for (i = 0; i < n_tests; i++) begin
      total += tbl_len[i] * 700;
      if (tbl_word[i][0][63:56] == stepper_cmd_pkg::CMD_CLK_DIVISOR) begin
        div = (tbl_word[i][0][7:0] == 8'd0) ? 1 : longint'(tbl_word[i][0][7:0]);
      end else if (tbl_word[i][0][63:56] == stepper_cmd_pkg::CMD_COORDINATED_STEP) begin
        total += longint'(tbl_word[i][1]) * div;
      end
    end
    return total;
  endfunction

  // DDA reference model that accumulates, ramps and steps on a bit 32 change
  function automatic int model_move(input logic [63:0] dur, input logic signed [63:0] inc_in,
                                    input logic signed [63:0] acc);
    logic signed [63:0] inc;
    logic signed [63:0] nxt;
    longint unsigned    t;
    int                 steps;
    inc   = inc_in;
    steps = 0;
    for (t = 0; t < dur; t++) begin
      nxt = model_accum + inc;
      if (nxt[32] != model_accum[32]) begin
        steps++;
      end
      model_accum = nxt;
      inc         = inc + acc;
    end
    return steps;
  endfunction

  // SPI mode 0 host with msb first and a half period of 4 clocks
  task automatic spi_word(input logic [63:0] tx, output logic [63:0] rx);
    int i;
    cs_n = 1'b0;
    repeat (6) @(negedge CLK);
    for (i = 63; i >= 0; i--) begin
      copi = tx[i];
      repeat (4) @(negedge CLK);
      rx[i] = cipo;
      sck   = 1'b1;
      repeat (4) @(negedge CLK);
      sck = 1'b0;
    end
    repeat (4) @(negedge CLK);
    cs_n = 1'b1;
    repeat (8) @(negedge CLK);
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic check_window(input string name, input longint exp, input longint got,
                              input longint slack);
    assert (got <= exp && got + slack >= exp) else begin
      $display("[ERROR] %s: expected %0d to %0d cycles, actual %0d", name, exp - slack, exp,
               got);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      $display("%-16s pass", name);
    end else begin
      $display("%-16s fail", name);
      failed_tests++;
    end
  endtask

  initial begin
    logic [63:0] rx;
    logic [63:0] enc_copy;
    logic [7:0]  op;
    logic        last_dir;
    int          i;
    int          w;
    int          model_steps;
    int          base_steps;
    int          base_done;
    int          batch_moves;
    int          errors_before;
    int          sva_fails;
    longint      div_now;
    longint      waited;
    bit          in_batch;
    bit          batch_end;

    seed          = 32'h4439_d27e;
    errors        = 0;
    failed_tests  = 0;
    model_accum   = '0;
    model_steps   = 0;
    base_steps    = 0;
    base_done     = 0;
    batch_moves   = 0;
    div_now       = `STEPPER_DEFAULT_DIVISOR;
    waited        = 0;
    in_batch      = 1'b0;
    last_dir      = 1'b0;
    arst_n        = 1'b0;
    sck           = 1'b0;
    cs_n          = 1'b1;
    copi          = 1'b0;
    encoder_count = '0;
    fill_table();
    wd_cycles = watchdog_budget();

    repeat (16) @(negedge CLK);
    arst_n = 1'b1;
    @(negedge CLK);
    errors_before = errors;
    check_value("reset.enable", 64'd0, {63'd0, enable});
    check_value("reset.step", 64'd0, {63'd0, step});
    check_value("reset.move_done", 64'd0, {63'd0, move_done});
    check_value("reset.buffer_dtr", 64'd1, {63'd0, buffer_dtr});
    check_value("reset.microsteps", `STEPPER_DEFAULT_MICROSTEPS, {61'd0, microsteps});
    check_value("reset.current", `STEPPER_DEFAULT_CURRENT, {56'd0, current});
    report_test("reset_defaults", errors_before);

    for (i = 0; i < n_tests; i++) begin
      errors_before = errors;
      op = tbl_word[i][0][63:56];
      if (op == stepper_cmd_pkg::CMD_COORDINATED_STEP && !in_batch) begin
        base_steps  = step_count;
        base_done   = done_count;
        model_steps = 0;
        batch_moves = 0;
        in_batch    = 1'b1;
      end
      encoder_count = {$random(seed), $random(seed)};
      enc_copy      = encoder_count;
      for (w = 0; w < tbl_len[i]; w++) begin
        spi_word(tbl_word[i][w], rx);
        if (w == 0) begin
          // Later changes must not reach the snapshot
          encoder_count = {$random(seed), $random(seed)};
        end
      end
      case (op)
        stepper_cmd_pkg::CMD_MOTOR_ENABLE: begin
          check_value({tbl_name[i], ".enable"}, tbl_exp[i], {63'd0, enable});
        end
        stepper_cmd_pkg::CMD_MOTOR_CONFIG: begin
          check_value({tbl_name[i], ".config"}, tbl_exp[i], {53'd0, microsteps, current});
        end
        stepper_cmd_pkg::CMD_API_VERSION: begin
          check_value({tbl_name[i], ".reply"}, tbl_exp[i], rx);
        end
        stepper_cmd_pkg::CMD_CLK_DIVISOR: begin
          div_now = tbl_exp[i];
        end
        stepper_cmd_pkg::CMD_COORDINATED_STEP: begin
          model_steps += model_move(tbl_word[i][1], tbl_word[i][2], tbl_word[i][3]);
          batch_moves++;
          last_dir = tbl_word[i][0][0];
          check_value({tbl_name[i], ".snapshot"}, enc_copy, rx);
          check_value({tbl_name[i], ".buffer_dtr"}, tbl_exp[i], {63'd0, buffer_dtr});
          // Room again once the running move retires
          while (!buffer_dtr) @(negedge CLK);
          if (i == n_tests - 1) begin
            batch_end = 1'b1;
          end else begin
            batch_end = (tbl_word[i + 1][0][63:56] != stepper_cmd_pkg::CMD_COORDINATED_STEP);
          end
          if (batch_end) begin
            waited = 0;
            while (done_count == base_done) begin
              @(negedge CLK);
              waited++;
            end
            repeat (16) @(negedge CLK);
            check_value({tbl_name[i], ".steps"}, model_steps, step_count - base_steps);
            check_value({tbl_name[i], ".done_pulses"}, 64'd1, done_count - base_done);
            check_value({tbl_name[i], ".dir"}, {63'd0, last_dir}, {63'd0, dir});
            // A lone move already runs while the tail of its last word goes out
            if (batch_moves == 1) begin
              check_window({tbl_name[i], ".duration"},
                           longint'(tbl_word[i][1]) * div_now, waited, 32);
            end
            in_batch = 1'b0;
          end
        end
        default: begin
        end
      endcase
      report_test(tbl_name[i], errors_before);
    end

    sva_fails = u_stepper_spi_top.u_queue.u_queue_sva.fail_count +
                u_stepper_spi_top.u_dda.u_dda_sva.fail_count;
    $display("Tests: %0d run, %0d failed, %0d check errors, %0d assertion failures",
             n_tests + 1, failed_tests, errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge CLK);
    $display("Timeout: the run did not finish within %0d clock cycles", wd_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* test/stepper_spi_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module stepper_spi_sva (
  input logic CLK,
  input logic arst_n,
  input logic push,
  input logic pop,
  input logic head_valid,
  input logic buffer_dtr,
  input logic step
);

  int fail_count = 0;

  // Step is a single-cycle pulse
  property step_one_cycle;
    @(posedge CLK) disable iff (!arst_n)
      step |=> !step;
  endproperty

  // The step generator only pops a present entry
  property pop_needs_entry;
    @(posedge CLK) disable iff (!arst_n)
      pop |-> head_valid;
  endproperty

  // Queue can only become full through a write
  property full_after_push;
    @(posedge CLK) disable iff (!arst_n)
      $fell(buffer_dtr) |-> $past(push);
  endproperty

  a_step_one_cycle: assert property (step_one_cycle)
    else begin
      $error("step stayed high for more than one cycle");
      fail_count++;
    end

  a_pop_needs_entry: assert property (pop_needs_entry)
    else begin
      $error("pop issued while the queue was empty");
      fail_count++;
    end

  a_full_after_push: assert property (full_after_push)
    else begin
      $error("buffer_dtr fell without a push");
      fail_count++;
    end

endmodule

`default_nettype wire

/* design/stepper_spi_top.sv */
`timescale 1ns/10ps
`default_nettype none

module stepper_spi_top (
  input  logic        CLK,
  input  logic        arst_n,
  input  logic        sck,
  input  logic        cs_n,
  input  logic        copi,
  input  logic [63:0] encoder_count,
  output logic        cipo,
  output logic        step,
  output logic        dir,
  output logic        enable,
  output logic [2:0]  microsteps,
  output logic [7:0]  current,
  output logic        buffer_dtr,
  output logic        move_done
);

  logic                          word_valid;
  stepper_cmd_pkg::cmd_word_u    word_data;
  logic [63:0]                   reply_word;
  logic [7:0]                    clock_divisor;

  // Decoder to queue
  logic                          push;
  logic                          move_dir;
  stepper_motion_pkg::duration_t move_duration;
  stepper_motion_pkg::rate_t     move_increment;
  stepper_motion_pkg::rate_t     move_accel;

  // Queue to step generator
  logic                          pop;
  logic                          head_valid;
  logic                          head_dir;
  stepper_motion_pkg::duration_t head_duration;
  stepper_motion_pkg::rate_t     head_increment;
  stepper_motion_pkg::rate_t     head_accel;

  spi_word_receiver u_receiver (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .sck        (sck),
    .cs_n       (cs_n),
    .copi       (copi),
    .reply_word (reply_word),
    .cipo       (cipo),
    .word_valid (word_valid),
    .word_data  (word_data)
  );

  spi_command_decoder u_decoder (
    .CLK            (CLK),
    .arst_n         (arst_n),
    .word_valid     (word_valid),
    .word_data      (word_data),
    .encoder_count  (encoder_count),
    .enable         (enable),
    .microsteps     (microsteps),
    .current        (current),
    .clock_divisor  (clock_divisor),
    .reply_word     (reply_word),
    .push           (push),
    .move_dir       (move_dir),
    .move_duration  (move_duration),
    .move_increment (move_increment),
    .move_accel     (move_accel)
  );

  move_queue u_queue (
    .CLK            (CLK),
    .arst_n         (arst_n),
    .push           (push),
    .move_dir       (move_dir),
    .move_duration  (move_duration),
    .move_increment (move_increment),
    .move_accel     (move_accel),
    .pop            (pop),
    .head_valid     (head_valid),
    .head_dir       (head_dir),
    .head_duration  (head_duration),
    .head_increment (head_increment),
    .head_accel     (head_accel),
    .buffer_dtr     (buffer_dtr)
  );

  dda_step_generator u_dda (
    .CLK            (CLK),
    .arst_n         (arst_n),
    .clock_divisor  (clock_divisor),
    .head_valid     (head_valid),
    .head_dir       (head_dir),
    .head_duration  (head_duration),
    .head_increment (head_increment),
    .head_accel     (head_accel),
    .pop            (pop),
    .step           (step),
    .dir            (dir),
    .move_done      (move_done)
  );

endmodule

`default_nettype wire

/* design/dda_step_generator.sv */
`timescale 1ns/10ps
`default_nettype none

module dda_step_generator (
  input  logic                          CLK,
  input  logic                          arst_n,
  input  logic [7:0]                    clock_divisor,
  input  logic                          head_valid,
  input  logic                          head_dir,
  input  stepper_motion_pkg::duration_t head_duration,
  input  stepper_motion_pkg::rate_t     head_increment,
  input  stepper_motion_pkg::rate_t     head_accel,
  output logic                          pop,
  output logic                          step,
  output logic                          dir,
  output logic                          move_done
);

  logic                          busy;
  logic [7:0]                    div_count;
  logic [7:0]                    div_limit;
  logic                          tick;
  stepper_motion_pkg::duration_t remaining;
  stepper_motion_pkg::rate_t     accum;
  stepper_motion_pkg::rate_t     accum_next;
  stepper_motion_pkg::rate_t     increment;
  stepper_motion_pkg::rate_t     accel;

  // Divisor 0 behaves as 1
  assign div_limit  = (clock_divisor == 8'd0) ? 8'd0 : clock_divisor - 8'd1;
  assign tick       = busy && (remaining != '0) && (div_count >= div_limit);
  assign accum_next = accum + increment;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pop       <= 1'b0;
      busy      <= 1'b0;
      div_count <= 8'd0;
      remaining <= '0;
      accum     <= '0;
      step      <= 1'b0;
      dir       <= 1'b0;
      move_done <= 1'b0;
    end else begin
      pop       <= 1'b0;
      step      <= 1'b0;
      move_done <= 1'b0;
      if (pop) begin
        // Head entry is still presented during the pop cycle
        busy      <= 1'b1;
        remaining <= head_duration;
        div_count <= 8'd0;
        dir       <= head_dir;
      end else if (!busy) begin
        if (head_valid) begin
          pop <= 1'b1;
        end
      end else if (remaining == '0) begin
        busy      <= 1'b0;
        move_done <= ~head_valid;
      end else if (tick) begin
        div_count <= 8'd0;
        remaining <= remaining - 1'b1;
        accum     <= accum_next;
        // Step on every crossing of an integer position
        step      <= accum_next[32] ^ accum[32];
      end else begin
        div_count <= div_count + 8'd1;
      end
    end
  end

  // Rate state, loaded from the queue and ramped by accel
  always_ff @(posedge CLK) begin
    if (pop) begin
      increment <= head_increment;
      accel     <= head_accel;
    end else if (tick) begin
      increment <= increment + accel;
    end
  end

endmodule

`default_nettype wire

/* design/move_queue.sv */
`timescale 1ns/10ps
`default_nettype none

`include "stepper_cfg.svh"

module move_queue (
  input  logic                          CLK,
  input  logic                          arst_n,
  input  logic                          push,
  input  logic                          move_dir,
  input  stepper_motion_pkg::duration_t move_duration,
  input  stepper_motion_pkg::rate_t     move_increment,
  input  stepper_motion_pkg::rate_t     move_accel,
  input  logic                          pop,
  output logic                          head_valid,
  output logic                          head_dir,
  output stepper_motion_pkg::duration_t head_duration,
  output stepper_motion_pkg::rate_t     head_increment,
  output stepper_motion_pkg::rate_t     head_accel,
  output logic                          buffer_dtr
);

  localparam int DEPTH = 1 << `STEPPER_MOVE_BUFFER_BITS;

  // Extra msb on each index separates full from empty
  logic [`STEPPER_MOVE_BUFFER_BITS:0] wr_ptr;
  logic [`STEPPER_MOVE_BUFFER_BITS:0] rd_ptr;
  stepper_motion_pkg::slot_t          wr_slot;
  stepper_motion_pkg::slot_t          rd_slot;
  logic                               full;

  logic                          dir_mem [DEPTH];
  stepper_motion_pkg::duration_t dur_mem [DEPTH];
  stepper_motion_pkg::rate_t     inc_mem [DEPTH];
  stepper_motion_pkg::rate_t     acc_mem [DEPTH];

  assign wr_slot    = wr_ptr[`STEPPER_MOVE_BUFFER_BITS-1:0];
  assign rd_slot    = rd_ptr[`STEPPER_MOVE_BUFFER_BITS-1:0];
  assign head_valid = (wr_ptr != rd_ptr);
  assign full       = (wr_ptr[`STEPPER_MOVE_BUFFER_BITS] != rd_ptr[`STEPPER_MOVE_BUFFER_BITS]) &&
                      (wr_slot == rd_slot);
  assign buffer_dtr = ~full;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      // A move pushed while full is dropped
      if (push && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop && head_valid) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (push && !full) begin
      dir_mem[wr_slot] <= move_dir;
      dur_mem[wr_slot] <= move_duration;
      inc_mem[wr_slot] <= move_increment;
      acc_mem[wr_slot] <= move_accel;
    end
  end

  assign head_dir       = dir_mem[rd_slot];
  assign head_duration  = dur_mem[rd_slot];
  assign head_increment = inc_mem[rd_slot];
  assign head_accel     = acc_mem[rd_slot];

endmodule

`default_nettype wire

/* design/spi_command_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "stepper_cfg.svh"

module spi_command_decoder (
  input  logic                          CLK,
  input  logic                          arst_n,
  input  logic                          word_valid,
  input  stepper_cmd_pkg::cmd_word_u    word_data,
  input  logic [63:0]                   encoder_count,
  output logic                          enable,
  output logic [2:0]                    microsteps,
  output logic [7:0]                    current,
  output logic [7:0]                    clock_divisor,
  output logic [63:0]                   reply_word,
  output logic                          push,
  output logic                          move_dir,
  output stepper_motion_pkg::duration_t move_duration,
  output stepper_motion_pkg::rate_t     move_increment,
  output stepper_motion_pkg::rate_t     move_accel
);

  stepper_cmd_pkg::opcode_e msg_header;
  stepper_cmd_pkg::header_t hdr;
  logic [1:0]               word_count;
  logic [63:0]              encoder_store;
  logic                     in_header;

  assign hdr       = word_data.hdr;
  assign in_header = (msg_header == stepper_cmd_pkg::CMD_NONE);

  // Message FSM and configuration registers
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      msg_header    <= stepper_cmd_pkg::CMD_NONE;
      word_count    <= 2'd0;
      enable        <= 1'b0;
      microsteps    <= `STEPPER_DEFAULT_MICROSTEPS;
      current       <= `STEPPER_DEFAULT_CURRENT;
      clock_divisor <= `STEPPER_DEFAULT_DIVISOR;
      reply_word    <= 64'd0;
      push          <= 1'b0;
    end else begin
      push <= 1'b0;
      if (word_valid) begin
        reply_word <= 64'd0;
        if (in_header) begin
          word_count <= 2'd1;
          case (hdr.opcode)
            stepper_cmd_pkg::CMD_COORDINATED_STEP: begin
              msg_header <= stepper_cmd_pkg::CMD_COORDINATED_STEP;
            end
            stepper_cmd_pkg::CMD_MOTOR_ENABLE: begin
              enable <= hdr.arg_b0[0];
            end
            stepper_cmd_pkg::CMD_CLK_DIVISOR: begin
              clock_divisor <= hdr.arg_b0;
            end
            stepper_cmd_pkg::CMD_MOTOR_CONFIG: begin
              current    <= hdr.arg_b1;
              microsteps <= hdr.arg_b0[2:0];
            end
            stepper_cmd_pkg::CMD_API_VERSION: begin
              reply_word <= {40'd0, `STEPPER_VERSION_MAJOR, `STEPPER_VERSION_MINOR,
                             `STEPPER_VERSION_PATCH};
              msg_header <= stepper_cmd_pkg::CMD_API_VERSION;
            end
            default: begin
            end
          endcase
        end else begin
          word_count <= word_count + 2'd1;
          if (msg_header == stepper_cmd_pkg::CMD_COORDINATED_STEP) begin
            if (word_count == 2'd2) begin
              // Encoder snapshot goes out during the last data word
              reply_word <= encoder_store;
            end else if (word_count == 2'd3) begin
              push       <= 1'b1;
              msg_header <= stepper_cmd_pkg::CMD_NONE;
            end
          end else begin
            // API version takes one trailing word of any value
            msg_header <= stepper_cmd_pkg::CMD_NONE;
          end
        end
      end
    end
  end

  // Move fields, complete by the time push fires
  always_ff @(posedge CLK) begin
    if (word_valid) begin
      if (in_header && hdr.opcode == stepper_cmd_pkg::CMD_COORDINATED_STEP) begin
        move_dir      <= hdr.arg_b0[0];
        encoder_store <= encoder_count;
      end
      if (msg_header == stepper_cmd_pkg::CMD_COORDINATED_STEP) begin
        case (word_count)
          2'd1: move_duration <= word_data.raw;
          2'd2: move_increment <= word_data.raw;
          2'd3: move_accel <= word_data.raw;
          default: begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* design/spi_word_receiver.sv */
`timescale 1ns/10ps
`default_nettype none

module spi_word_receiver (
  input  logic                       CLK,
  input  logic                       arst_n,
  input  logic                       sck,
  input  logic                       cs_n,
  input  logic                       copi,
  input  logic [63:0]                reply_word,
  output logic                       cipo,
  output logic                       word_valid,
  output stepper_cmd_pkg::cmd_word_u word_data
);

  logic [1:0]  sck_sync;
  logic [1:0]  cs_sync;
  logic [1:0]  copi_sync;
  logic        sck_prev;
  logic        cs_prev;
  logic        sck_rise;
  logic        sck_fall;
  logic        cs_fall;
  logic [5:0]  bit_count;
  logic        valid_d;
  logic [63:0] rx_shift;
  logic [63:0] tx_shift;

  // Two-flop synchronizers plus previous values for edge detection
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      sck_sync  <= 2'b00;
      cs_sync   <= 2'b11;
      copi_sync <= 2'b00;
      sck_prev  <= 1'b0;
      cs_prev   <= 1'b1;
    end else begin
      sck_sync  <= {sck_sync[0], sck};
      cs_sync   <= {cs_sync[0], cs_n};
      copi_sync <= {copi_sync[0], copi};
      sck_prev  <= sck_sync[1];
      cs_prev   <= cs_sync[1];
    end
  end

  assign sck_rise = sck_sync[1] & ~sck_prev;
  assign sck_fall = ~sck_sync[1] & sck_prev;
  assign cs_fall  = ~cs_sync[1] & cs_prev;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      bit_count  <= 6'd0;
      word_valid <= 1'b0;
      valid_d    <= 1'b0;
      tx_shift   <= 64'd0;
    end else begin
      word_valid <= 1'b0;
      valid_d    <= word_valid;
      // Deselect drops any partial word
      if (cs_sync[1]) begin
        bit_count <= 6'd0;
      end else if (sck_rise) begin
        // Count wraps to zero after the 64th bit
        bit_count <= bit_count + 6'd1;
        if (bit_count == 6'd63) begin
          word_valid <= 1'b1;
        end
      end
      // Reload once the decoder has registered its new reply
      if (cs_fall || valid_d) begin
        tx_shift <= reply_word;
      end else if (sck_fall && !cs_sync[1] && bit_count != 6'd0) begin
        // Trailing falling edge after a full word is skipped
        tx_shift <= {tx_shift[62:0], 1'b0};
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (sck_rise && !cs_sync[1]) begin
      rx_shift <= {rx_shift[62:0], copi_sync[1]};
      if (bit_count == 6'd63) begin
        word_data.raw <= {rx_shift[62:0], copi_sync[1]};
      end
    end
  end

  assign cipo = tx_shift[63];

endmodule

`default_nettype wire

/* design/stepper_motion_pkg.sv */
`default_nettype none

`include "stepper_cfg.svh"

package stepper_motion_pkg;

  // Move length in DDA ticks
  typedef logic [63:0] duration_t;

  // 32.32 signed fixed point for rates and the position accumulator
  typedef logic signed [63:0] rate_t;

  // Index into the move queue
  typedef logic [`STEPPER_MOVE_BUFFER_BITS-1:0] slot_t;

endpackage

`default_nettype wire

/* design/stepper_cmd_pkg.sv */
`default_nettype none

package stepper_cmd_pkg;

  // Command codes carried in the top byte of a header word
  typedef enum logic [7:0] {
    CMD_NONE             = 8'h00,
    CMD_COORDINATED_STEP = 8'h01,
    CMD_MOTOR_ENABLE     = 8'h0a,
    CMD_CLK_DIVISOR      = 8'h0b,
    CMD_MOTOR_CONFIG     = 8'h10,
    CMD_API_VERSION      = 8'hfe
  } opcode_e;

  // Header layout, msb first on the wire
  typedef struct packed {
    opcode_e     opcode;
    logic [39:0] reserved;
    // Motor current
    logic [7:0]  arg_b1;
    // Enable, direction, microsteps or divisor
    logic [7:0]  arg_b0;
  } header_t;

  // Same 64 bits seen as a header or as a data word
  typedef union packed {
    header_t     hdr;
    logic [63:0] raw;
  } cmd_word_u;

endpackage

`default_nettype wire

/* design/stepper_cfg.svh */
`ifndef STEPPER_CFG_SVH
`define STEPPER_CFG_SVH

// Move queue depth as a power of two
`define STEPPER_MOVE_BUFFER_BITS 2

// API version returned to the host, patch in the lowest byte
`define STEPPER_VERSION_MAJOR 8'd1
`define STEPPER_VERSION_MINOR 8'd0
`define STEPPER_VERSION_PATCH 8'd2

// Reset values of the motor configuration
// Divisor of 40 gives a 400 kHz tick from a 16 MHz clock
`define STEPPER_DEFAULT_DIVISOR 8'd40
`define STEPPER_DEFAULT_MICROSTEPS 3'd2
`define STEPPER_DEFAULT_CURRENT 8'd140

`endif
